// File: mipsExecCore.f
+incdir+verilog
verilog/cpuTypesPkg.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/executeUnit.sv
verilog/mipsExecCore.sv
test/mipsExecCore_chk.sv
test/mipsExecCore_tb.sv

// File: run.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log.
# A failed build or an aborted run counts as a failed test.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

{ verilator --binary --timing --assert -f mipsExecCore.f \
    --top-module mipsExecCore_tb -Mdir obj_dir \
  && ./obj_dir/VmipsExecCore_tb; } > sim.log 2>&1 \
  || echo "*** TEST FAILED ***" >> sim.log

cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

// File: test/mipsExecCore_chk.sv
/*
  Protocol checker for the execution core, attached to the top level with bind.
  Watches the strobe, the result valid pulse and the halted level.
*/
`timescale 1ns/1ns

module mipsExecCore_chk (
  input logic CLK,
  input logic nRST,
  input logic instrValid,
  input logic resultValid,
  input logic halted
);

  logic accepted;

  assign accepted = instrValid && !halted; // core only takes strobes in RUN

  resultAfterStrobe: assert property (@(posedge CLK) disable iff (!nRST)
    accepted |=> resultValid)
    else $error("accepted strobe not followed by a result one cycle later");

  noSpuriousResult: assert property (@(posedge CLK) disable iff (!nRST)
    resultValid |-> $past(accepted))
    else $error("result valid without an accepted strobe in the cycle before");

  haltIsSticky: assert property (@(posedge CLK) disable iff (!nRST)
    !$fell(halted))
    else $error("halted dropped while reset was inactive");

endmodule

bind mipsExecCore mipsExecCore_chk mipsExecCore_chk_i (
  .CLK         (CLK),
  .nRST        (nRST),
  .instrValid  (instrValid),
  .resultValid (resultValid),
  .halted      (halted)
);

// File: test/mipsExecCore_tb.sv
/*
  Testbench for the execution core. Feeds an LFSR-generated instruction
  stream plus a few directed sequences, predicts every result record with a
  reference model and compares. Ends with halt and a second reset.
*/
`timescale 1ns/1ns
`include "cpu_consts.svh"

module mipsExecCore_tb;

  localparam int resetCycles   = 16;
  localparam int numRandom     = 400;
  localparam int maxInstrs     = numRandom + 64; // directed phases fit in the extra
  localparam int timeoutCycles = 4 * (2 * resetCycles + 4 * maxInstrs);

  localparam cpuTypesPkg::funct_t functTable [13] = '{`FN_ADD, `FN_ADDU, `FN_SUB,
    `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_JR};
  localparam cpuTypesPkg::opcode_t opTable [12] = '{`OP_ADDIU, `OP_SLTI, `OP_SLTIU,
    `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI, `OP_BEQ, `OP_BNE, `OP_J, `OP_JAL, `OP_SW};
  localparam cpuTypesPkg::opcode_t badOpTable [3] = '{`OP_LW, 6'h01, 6'h1c};

  logic CLK, nRST, instrValid;
  cpuTypesPkg::word_t   instr;
  logic                 resultValid;
  cpuTypesPkg::result_t result;
  logic                 halted;

  cpuTypesPkg::word_t lfsrState;
  cpuTypesPkg::word_t modelRegs [`NUM_REGS];
  cpuTypesPkg::word_t modelPc;
  string              testName;
  int                 cycleCount;

  mipsExecCore mipsExecCore_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .instrValid  (instrValid),
    .instr       (instr),
    .resultValid (resultValid),
    .result      (result),
    .halted      (halted)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // watchdog
  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge CLK);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
    $display("*** TEST FAILED ***");
    $fatal(1, "run timed out");
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic cpuTypesPkg::word_t randBits(input int n);
    cpuTypesPkg::word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = {lfsrState[30:0],
                   lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic cpuTypesPkg::word_t randomInstr();
    cpuTypesPkg::word_t w;
    logic [3:0]  group;
    logic [4:0]  rs, rt, rd, sh;
    logic [15:0] imm;
    int          sel;
    group = 4'(randBits(4));
    rs    = 5'(randBits(3)); // few registers so operands collide often
    rt    = 5'(randBits(3));
    rd    = 5'(randBits(3));
    sh    = 5'(randBits(5));
    imm   = 16'(randBits(16));
    if (group < 4'd7) begin
      sel = int'(randBits(4) % 32'd13);
      w   = {`OP_RTYPE, rs, rt, rd, sh, functTable[sel]};
    end else if (group < 4'd15) begin
      sel = int'(randBits(4) % 32'd12);
      w   = {opTable[sel], rs, rt, imm};
    end else begin
      sel = int'(randBits(2)); // illegal, 1 in 16
      if (sel == 3) begin
        w = {`OP_RTYPE, rs, rt, rd, sh, 6'h3f};
      end else begin
        w = {badOpTable[sel], rs, rt, imm};
      end
    end
    return w;
  endfunction

  // reference model, one instruction
  task automatic predict(input cpuTypesPkg::word_t w, output cpuTypesPkg::result_t exp);
    cpuTypesPkg::word_t   a, b, sext, zext, pc4, val;
    cpuTypesPkg::regIdx_t dst;
    logic                 wr;
    a    = modelRegs[w[25:21]];
    b    = modelRegs[w[20:16]];
    sext = {{16{w[15]}}, w[15:0]};
    zext = {16'h0000, w[15:0]};
    pc4  = modelPc + 32'd4;
    exp        = '0;
    exp.pc     = modelPc;
    exp.nextPc = pc4;
    dst = w[20:16]; // I-type target
    val = '0;
    wr  = 1'b1;
    case (w[31:26])
      `OP_RTYPE: begin
        dst = w[15:11];
        case (w[5:0])
          `FN_ADD, `FN_ADDU: val = a + b;
          `FN_SUB, `FN_SUBU: val = a - b;
          `FN_AND:  val = a & b;
          `FN_OR:   val = a | b;
          `FN_XOR:  val = a ^ b;
          `FN_NOR:  val = ~(a | b);
          `FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          `FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
          `FN_SLL:  val = b << w[10:6];
          `FN_SRL:  val = b >> w[10:6];
          `FN_JR: begin
            wr         = 1'b0;
            exp.nextPc = a;
          end
          default: wr = 1'b0;
        endcase
      end
      `OP_ADDIU: val = a + sext;
      `OP_SLTI:  val = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
      `OP_SLTIU: val = (a < sext) ? 32'd1 : 32'd0;
      `OP_ANDI:  val = a & zext;
      `OP_ORI:   val = a | zext;
      `OP_XORI:  val = a ^ zext;
      `OP_LUI:   val = {w[15:0], 16'h0000};
      `OP_J, `OP_JAL: begin
        exp.nextPc = {pc4[31:28], w[25:0], 2'b00};
        wr         = (w[31:26] == `OP_JAL);
        dst        = 5'(`LINK_REG);
        val        = pc4;
      end
      `OP_BEQ, `OP_BNE: begin
        wr = 1'b0;
        if ((a == b) == (w[31:26] == `OP_BEQ)) begin
          exp.nextPc = pc4 + {sext[29:0], 2'b00};
        end
      end
      `OP_SW: begin
        wr            = 1'b0;
        exp.storeEn   = 1'b1;
        exp.storeAddr = a + sext;
        exp.storeData = b;
      end
      `OP_HALT: begin
        wr         = 1'b0;
        exp.halted = 1'b1;
      end
      default: wr = 1'b0;
    endcase
    exp.wrEn   = wr;
    exp.wrIdx  = dst;
    exp.wrData = val;
    if (wr && dst != '0) begin
      modelRegs[dst] = val;
    end
    modelPc = exp.nextPc;
  endtask

  task automatic checkField(input string field, input cpuTypesPkg::word_t expV,
                            input cpuTypesPkg::word_t actV);
    assert (actV === expV) else begin
      $display("Error %s/%s expected %h actual %h", testName, field, expV, actV);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch in %s", field);
    end
  endtask

  task automatic compareResult(input cpuTypesPkg::result_t exp);
    checkField("pc", exp.pc, result.pc);
    checkField("nextPc", exp.nextPc, result.nextPc);
    checkField("wrEn", 32'(exp.wrEn), 32'(result.wrEn));
    if (exp.wrEn) begin
      checkField("wrIdx", 32'(exp.wrIdx), 32'(result.wrIdx));
      checkField("wrData", exp.wrData, result.wrData);
    end
    checkField("storeEn", 32'(exp.storeEn), 32'(result.storeEn));
    if (exp.storeEn) begin
      checkField("storeAddr", exp.storeAddr, result.storeAddr);
      checkField("storeData", exp.storeData, result.storeData);
    end
    checkField("halted", 32'(exp.halted), 32'(result.halted));
  endtask

  // strobe one instruction, wait for its record, then idle 1 to 3 cycles
  task automatic issue(input cpuTypesPkg::word_t w);
    cpuTypesPkg::result_t exp;
    int                   gap;
    predict(w, exp);
    instr      = w;
    instrValid = 1'b1;
    @(posedge CLK);
    #1;
    instrValid = 1'b0;
    while (resultValid !== 1'b1) begin
      @(posedge CLK);
      #1;
    end
    compareResult(exp);
    gap = 1 + int'(randBits(2) % 32'd3);
    repeat (gap) @(posedge CLK);
    #1;
  endtask

  task automatic issueIgnored(input cpuTypesPkg::word_t w);
    instr      = w;
    instrValid = 1'b1;
    @(posedge CLK);
    #1;
    instrValid = 1'b0;
    assert (resultValid === 1'b0) else begin
      $display("Strobe after halt produced a result in test %s", testName);
      $display("*** TEST FAILED ***");
      $fatal(1, "result while halted");
    end
    repeat (2) @(posedge CLK);
    #1;
  endtask

  task automatic applyReset();
    nRST       = 1'b0;
    instrValid = 1'b0;
    repeat (resetCycles) @(posedge CLK);
    #1;
    nRST = 1'b1;
    for (int i = 0; i < `NUM_REGS; i++) begin
      modelRegs[i] = '0;
    end
    modelPc = '0;
  endtask

  initial begin
    lfsrState  = 32'h9f7f_5593;
    nRST       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    testName   = "reset";
    applyReset();

    testName = "r0";
    issue({`OP_ADDIU, 5'd0, 5'd0, 16'h1234}); // write to r0 dropped
    issue({`OP_SW, 5'd0, 5'd0, 16'h0010});

    testName = "random";
    for (int i = 0; i < numRandom; i++) begin
      issue(randomInstr());
    end

    testName = "halt";
    issue({`OP_HALT, 26'd0});
    checkField("haltedLevel", 32'd1, 32'(halted));
    repeat (3) issueIgnored(randomInstr());

    // registers and PC back to zero, read out through store data
    testName = "afterReset";
    applyReset();
    checkField("haltedLevel", 32'd0, 32'(halted));
    for (int r = 0; r < `NUM_REGS; r++) begin
      issue({`OP_SW, 5'(r), 5'(r), 16'h0000});
    end
    for (int i = 0; i < 20; i++) begin
      issue(randomInstr());
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: verilog/controlUnit.sv
/*
  Combinational instruction decoder. Splits the instruction word into its
  fields and turns opcode and funct into the control word used by the
  execute unit. Unknown codes are flagged illegal and retire as no-ops.
*/
`timescale 1ns/1ns
`include "cpu_consts.svh"

module controlUnit (
  input  cpuTypesPkg::word_t instr,
  output cpuTypesPkg::ctrl_t ctrl
);

  cpuTypesPkg::opcode_t opcode;
  cpuTypesPkg::funct_t  funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  always_comb begin
    // everything off, then switch on per instruction
    ctrl            = '0;
    ctrl.aluOp      = cpuTypesPkg::ALU_ADD;
    ctrl.signExtend = 1'b1;
    ctrl.rs         = instr[25:21];
    ctrl.rt         = instr[20:16];
    ctrl.rd         = instr[15:11];
    ctrl.shamt      = instr[10:6];
    ctrl.imm16      = instr[15:0];

    case (opcode)
      `OP_RTYPE: begin
        ctrl.regDst = 1'b1; // R-type writes rd
        ctrl.regWr  = 1'b1;
        case (funct)
          `FN_ADD, `FN_ADDU: ctrl.aluOp = cpuTypesPkg::ALU_ADD;
          `FN_SUB, `FN_SUBU: ctrl.aluOp = cpuTypesPkg::ALU_SUB;
          `FN_AND:           ctrl.aluOp = cpuTypesPkg::ALU_AND;
          `FN_OR:            ctrl.aluOp = cpuTypesPkg::ALU_OR;
          `FN_XOR:           ctrl.aluOp = cpuTypesPkg::ALU_XOR;
          `FN_NOR:           ctrl.aluOp = cpuTypesPkg::ALU_NOR;
          `FN_SLT:           ctrl.aluOp = cpuTypesPkg::ALU_SLT;
          `FN_SLTU:          ctrl.aluOp = cpuTypesPkg::ALU_SLTU;
          `FN_SLL: begin
            ctrl.aluOp        = cpuTypesPkg::ALU_SLL;
            ctrl.shiftOperand = 1'b1;
          end
          `FN_SRL: begin
            ctrl.aluOp        = cpuTypesPkg::ALU_SRL;
            ctrl.shiftOperand = 1'b1;
          end
          `FN_JR: begin
            ctrl.jumpReg = 1'b1;
            ctrl.regWr   = 1'b0; // no writeback
          end
          default: begin
            ctrl.illegal = 1'b1;
            ctrl.regWr   = 1'b0;
          end
        endcase
      end

      `OP_J: ctrl.jumpImm = 1'b1;
      `OP_JAL: begin
        ctrl.jumpImm = 1'b1;
        ctrl.link    = 1'b1;
        ctrl.regWr   = 1'b1;
      end

      // compare happens in execute, alu result unused
      `OP_BEQ: ctrl.isBranchEq = 1'b1;
      `OP_BNE: ctrl.isBranchNe = 1'b1;

      `OP_ADDIU: begin
        ctrl.immOperand = 1'b1;
        ctrl.regWr      = 1'b1;
      end
      `OP_SLTI: begin
        ctrl.aluOp      = cpuTypesPkg::ALU_SLT;
        ctrl.immOperand = 1'b1;
        ctrl.regWr      = 1'b1;
      end
      `OP_SLTIU: begin
        ctrl.aluOp      = cpuTypesPkg::ALU_SLTU; // imm still sign-extended
        ctrl.immOperand = 1'b1;
        ctrl.regWr      = 1'b1;
      end

      // logical immediates zero-extend
      `OP_ANDI: begin
        ctrl.aluOp      = cpuTypesPkg::ALU_AND;
        ctrl.immOperand = 1'b1;
        ctrl.signExtend = 1'b0;
        ctrl.regWr      = 1'b1;
      end
      `OP_ORI: begin
        ctrl.aluOp      = cpuTypesPkg::ALU_OR;
        ctrl.immOperand = 1'b1;
        ctrl.signExtend = 1'b0;
        ctrl.regWr      = 1'b1;
      end
      `OP_XORI: begin
        ctrl.aluOp      = cpuTypesPkg::ALU_XOR;
        ctrl.immOperand = 1'b1;
        ctrl.signExtend = 1'b0;
        ctrl.regWr      = 1'b1;
      end

      `OP_LUI: begin
        ctrl.aluOp      = cpuTypesPkg::ALU_LUI;
        ctrl.immOperand = 1'b1;
        ctrl.regWr      = 1'b1;
      end

      `OP_SW: begin
        ctrl.immOperand = 1'b1;
        ctrl.store      = 1'b1;
      end
      `OP_HALT: ctrl.halt = 1'b1;

      `OP_LW:  ctrl.illegal = 1'b1; // loads need a data memory
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

// File: verilog/cpuTypesPkg.sv
/*
  Shared types of the execution core: word and field widths, the ALU
  operation and core state encodings, and the control and result records.
  Referenced by scoped name from the RTL and the testbench.
*/
package cpuTypesPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;

  // operations the ALU knows
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,  // signed compare
    ALU_SLTU, // unsigned compare
    ALU_SLL,
    ALU_SRL,
    ALU_LUI   // imm16 into upper half
  } aluOp_t;

  typedef enum logic {
    RUN,
    HALTED
  } coreState_t;

  // decoded instruction, decoder to execute unit
  typedef struct packed {
    aluOp_t      aluOp;
    logic        immOperand;   // B operand is the immediate
    logic        shiftOperand; // shift amount from shamt
    logic        signExtend;
    logic        regDst;       // 1 selects rd, 0 selects rt
    logic        regWr;
    logic        link;         // JAL writes PC+4 to the link register
    logic        isBranchEq;
    logic        isBranchNe;
    logic        jumpImm;      // J and JAL
    logic        jumpReg;      // JR
    logic        store;
    logic        halt;
    logic        illegal;
    regIdx_t     rs;
    regIdx_t     rt;
    regIdx_t     rd;
    logic [4:0]  shamt;
    logic [15:0] imm16;
  } ctrl_t;

  // one record per retired instruction
  typedef struct packed {
    word_t   pc;
    word_t   nextPc;
    logic    wrEn;
    regIdx_t wrIdx;
    word_t   wrData;
    logic    storeEn;
    word_t   storeAddr;
    word_t   storeData;
    logic    halted;
  } result_t;

endpackage

// File: verilog/cpu_consts.svh
/*
  Opcode and function-field encodings plus register file constants
  for the single-cycle execution core. Include wherever the codes are decoded.
*/
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// register file geometry
`define NUM_REGS 32
`define LINK_REG 31 // JAL target register

// primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00 // decode continues on funct
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0a
`define OP_SLTIU 6'h0b
`define OP_ANDI  6'h0c // zero-extended imm
`define OP_ORI   6'h0d // zero-extended imm
`define OP_XORI  6'h0e // zero-extended imm
`define OP_LUI   6'h0f
`define OP_LW    6'h23 // decoded only, no data memory
`define OP_SW    6'h2b
`define OP_HALT  6'h3f

// function field for R-type, instr[5:0]
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_JR   6'h08
`define FN_ADD  6'h20 // no overflow trap, same as ADDU
`define FN_ADDU 6'h21
`define FN_SUB  6'h22 // no overflow trap, same as SUBU
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_NOR  6'h27
`define FN_SLT  6'h2a
`define FN_SLTU 6'h2b

`endif

// File: verilog/executeUnit.sv
/*
  Execute stage of the core. Runs the ALU, resolves branches and jumps,
  holds the PC and the halt state machine, drives the register write port
  and registers one result record per accepted instruction.
*/
`timescale 1ns/1ns
`include "cpu_consts.svh"

module executeUnit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   instrValid,
  input  cpuTypesPkg::ctrl_t     ctrl,
  input  cpuTypesPkg::word_t     rsData,
  input  cpuTypesPkg::word_t     rtData,
  output logic                   wrEn,
  output cpuTypesPkg::regIdx_t   wrIdx,
  output cpuTypesPkg::word_t     wrData,
  output logic                   resultValid,
  output cpuTypesPkg::result_t   result,
  output logic                   halted
);

  cpuTypesPkg::coreState_t state;
  cpuTypesPkg::word_t      pc;
  cpuTypesPkg::word_t      pcPlus4;
  cpuTypesPkg::word_t      immSext;
  cpuTypesPkg::word_t      immExt;
  cpuTypesPkg::word_t      opB;
  cpuTypesPkg::word_t      aluOut;
  cpuTypesPkg::word_t      branchTarget;
  cpuTypesPkg::word_t      jumpTarget;
  cpuTypesPkg::word_t      nextPc;
  logic [4:0]              shAmt;
  logic                    accept;
  logic                    taken;

  assign accept = instrValid && (state == cpuTypesPkg::RUN); // strobes ignored once halted

  // operand selection
  assign pcPlus4 = pc + 32'd4;
  assign immSext = {{16{ctrl.imm16[15]}}, ctrl.imm16};
  assign immExt  = ctrl.signExtend ? immSext : {16'h0000, ctrl.imm16};
  assign opB     = ctrl.immOperand ? immExt : rtData;
  assign shAmt   = ctrl.shiftOperand ? ctrl.shamt : rsData[4:0];

  always_comb begin
    case (ctrl.aluOp)
      cpuTypesPkg::ALU_ADD:  aluOut = rsData + opB;
      cpuTypesPkg::ALU_SUB:  aluOut = rsData - opB;
      cpuTypesPkg::ALU_AND:  aluOut = rsData & opB;
      cpuTypesPkg::ALU_OR:   aluOut = rsData | opB;
      cpuTypesPkg::ALU_XOR:  aluOut = rsData ^ opB;
      cpuTypesPkg::ALU_NOR:  aluOut = ~(rsData | opB);
      cpuTypesPkg::ALU_SLT:  aluOut = {31'b0, $signed(rsData) < $signed(opB)};
      cpuTypesPkg::ALU_SLTU: aluOut = {31'b0, rsData < opB};
      cpuTypesPkg::ALU_SLL:  aluOut = opB << shAmt; // shifts act on rt
      cpuTypesPkg::ALU_SRL:  aluOut = opB >> shAmt;
      cpuTypesPkg::ALU_LUI:  aluOut = {ctrl.imm16, 16'h0000};
      default:               aluOut = '0;
    endcase
  end

  // next PC
  assign taken = (ctrl.isBranchEq && (rsData == rtData)) ||
                 (ctrl.isBranchNe && (rsData != rtData));
  assign branchTarget = pcPlus4 + {immSext[29:0], 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], ctrl.rs, ctrl.rt, ctrl.imm16, 2'b00};

  always_comb begin
    if (ctrl.jumpReg) begin
      nextPc = rsData;
    end else if (ctrl.jumpImm) begin
      nextPc = jumpTarget;
    end else if (taken) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4; // includes illegal and halt
    end
  end

  // writeback port
  assign wrEn   = accept && ctrl.regWr;
  assign wrIdx  = ctrl.link ? cpuTypesPkg::regIdx_t'(`LINK_REG) :
                  (ctrl.regDst ? ctrl.rd : ctrl.rt);
  assign wrData = ctrl.link ? pcPlus4 : aluOut;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state       <= cpuTypesPkg::RUN;
      pc          <= '0;
      resultValid <= 1'b0;
    end else begin
      resultValid <= accept;
      if (accept) begin
        pc <= nextPc;
        if (ctrl.halt) state <= cpuTypesPkg::HALTED; // only reset leaves
      end
    end
  end

  // result record payload, only meaningful with resultValid
  always_ff @(posedge CLK) begin
    if (accept) begin
      result.pc        <= pc;
      result.nextPc    <= nextPc;
      result.wrEn      <= wrEn;
      result.wrIdx     <= wrIdx;
      result.wrData    <= wrData;
      result.storeEn   <= ctrl.store;
      result.storeAddr <= rsData + immSext;
      result.storeData <= rtData;
      result.halted    <= ctrl.halt;
    end
  end

  assign halted = (state == cpuTypesPkg::HALTED);

endmodule

// File: verilog/mipsExecCore.sv
/*
  Top level of the single-cycle execution core. The decoder and the
  register file work on the same instruction in parallel and the execute
  unit combines them. Result appears one cycle after each accepted strobe.
*/
`timescale 1ns/1ns

module mipsExecCore (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 instrValid,
  input  cpuTypesPkg::word_t   instr,
  output logic                 resultValid,
  output cpuTypesPkg::result_t result,
  output logic                 halted
);

  cpuTypesPkg::ctrl_t   ctrl;
  cpuTypesPkg::word_t   rsData;
  cpuTypesPkg::word_t   rtData;
  logic                 wrEn;
  cpuTypesPkg::regIdx_t wrIdx;
  cpuTypesPkg::word_t   wrData;

  controlUnit controlUnit_i (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // operand reads straight from the decoded fields
  registerFile registerFile_i (
    .CLK    (CLK),
    .nRST   (nRST),
    .rsIdx  (ctrl.rs),
    .rtIdx  (ctrl.rt),
    .rsData (rsData),
    .rtData (rtData),
    .wrEn   (wrEn),
    .wrIdx  (wrIdx),
    .wrData (wrData)
  );

  executeUnit executeUnit_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .instrValid  (instrValid),
    .ctrl        (ctrl),
    .rsData      (rsData),
    .rtData      (rtData),
    .wrEn        (wrEn),
    .wrIdx       (wrIdx),
    .wrData      (wrData),
    .resultValid (resultValid),
    .result      (result),
    .halted      (halted)
  );

endmodule

// File: verilog/registerFile.sv
/*
  General purpose register file with two combinational read ports and one
  clocked write port. Register 0 ignores writes and always reads as zero.
*/
`timescale 1ns/1ns
`include "cpu_consts.svh"

module registerFile (
  input  logic                 CLK,
  input  logic                 nRST,
  input  cpuTypesPkg::regIdx_t rsIdx,
  input  cpuTypesPkg::regIdx_t rtIdx,
  output cpuTypesPkg::word_t   rsData,
  output cpuTypesPkg::word_t   rtData,
  input  logic                 wrEn,
  input  cpuTypesPkg::regIdx_t wrIdx,
  input  cpuTypesPkg::word_t   wrData
);

  cpuTypesPkg::word_t regs [`NUM_REGS];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrIdx != '0)) begin // r0 write dropped
      regs[wrIdx] <= wrData;
    end
  end

  // read ports
  assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
  assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

endmodule
